// ==== src/scaler_settings.svh ====
`ifndef SCALER_SETTINGS_SVH
`define SCALER_SETTINGS_SVH

// Bits per pixel, single channel
`define SCALER_PIXEL_WIDTH 8

// Width, height and column index bits
`define SCALER_RESO_WIDTH 10

// Blend weights run from 0 to this many quarters
`define SCALER_WEIGHT_STEPS 4

// Line buffers in the write rotation
`define SCALER_BUF_NUM 4

`endif

// ==== src/scaler_pkg.sv ====
`default_nettype none

`include "scaler_settings.svh"

package scaler_pkg;

	typedef logic [`SCALER_PIXEL_WIDTH-1:0] pixel_t;
	typedef logic [`SCALER_RESO_WIDTH-1:0] reso_t;

	// Half-pixel position, compared modulo its width
	typedef logic [`SCALER_RESO_WIDTH:0] mul_t;

	typedef logic [$clog2(`SCALER_WEIGHT_STEPS+1)-1:0] weight_t;
	typedef logic [$clog2(`SCALER_BUF_NUM)-1:0] buf_sel_t;

	// Bit 1 set means an output is pending for the current column
	typedef enum logic [1:0] {
		COL_IDLE   = 2'b00,
		COL_SKIP   = 2'b01,
		COL_SINGLE = 2'b10,
		COL_MULTI  = 2'b11
	} col_state_e;

endpackage

`default_nettype wire

// ==== src/line_buffer.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "scaler_settings.svh"

module line_buffer (
	input  wire                  clk,
	input  wire                  i_wr_en,
	input  wire scaler_pkg::reso_t  i_wr_addr,
	input  wire scaler_pkg::pixel_t i_wr_data,
	input  wire                  i_rd_en,
	input  wire scaler_pkg::reso_t  i_rd_addr,
	output scaler_pkg::pixel_t      o_rd_data
);

	scaler_pkg::pixel_t mem [2**`SCALER_RESO_WIDTH];

	always_ff @(posedge clk) begin
		if (i_wr_en)
			mem[i_wr_addr] <= i_wr_data;
	end

	// Registered read for block RAM
	always_ff @(posedge clk) begin
		if (i_rd_en)
			o_rd_data <= mem[i_rd_addr];
	end

endmodule

`default_nettype wire

// ==== src/scale_control.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "scaler_settings.svh"

module scale_control (
	input  wire                     clk,
	input  wire                     int_reset,
	input  wire scaler_pkg::reso_t  i_s_width,
	input  wire scaler_pkg::reso_t  i_s_height,
	input  wire scaler_pkg::reso_t  i_m_width,
	input  wire scaler_pkg::reso_t  i_m_height,
	input  wire                     i_s_tvalid,
	input  wire scaler_pkg::pixel_t i_s_tdata,
	input  wire                     i_s_tlast,
	output logic                    o_s_tready,
	output logic [`SCALER_BUF_NUM-1:0] o_wr_en,
	output scaler_pkg::reso_t       o_wr_addr,
	output scaler_pkg::pixel_t      o_wr_data,
	output logic                    o_rd_en,
	output scaler_pkg::reso_t       o_rd_addr,
	input  wire scaler_pkg::pixel_t i_rd_data0,
	input  wire scaler_pkg::pixel_t i_rd_data1,
	input  wire scaler_pkg::pixel_t i_rd_data2,
	input  wire scaler_pkg::pixel_t i_rd_data3,
	output logic                    o_pair_valid,
	input  wire                     i_pair_ready,
	output scaler_pkg::pixel_t      o_tl,
	output scaler_pkg::pixel_t      o_bl,
	output scaler_pkg::pixel_t      o_tr,
	output scaler_pkg::pixel_t      o_br,
	output scaler_pkg::weight_t     o_y_weight,
	output scaler_pkg::weight_t     o_x_weight,
	output logic                    o_pair_last
);

	// Positions wrap, so order is taken from the sign of the difference
	function automatic logic mul_ge(input scaler_pkg::mul_t a, input scaler_pkg::mul_t b);
		scaler_pkg::mul_t d;
		d = a - b;
		return ~d[`SCALER_RESO_WIDTH];
	endfunction

	function automatic scaler_pkg::weight_t quantize(input scaler_pkg::mul_t diff,
			input scaler_pkg::mul_t thr [`SCALER_WEIGHT_STEPS]);
		scaler_pkg::weight_t w;
		w = scaler_pkg::weight_t'(`SCALER_WEIGHT_STEPS);
		for (int i = `SCALER_WEIGHT_STEPS - 1; i >= 0; i--) begin
			if (diff <= thr[i])
				w = scaler_pkg::weight_t'(i);
		end
		return w;
	endfunction

	scaler_pkg::mul_t s_w2, s_h2, m_w2, m_h2;
	assign s_w2 = {i_s_width, 1'b0};
	assign s_h2 = {i_s_height, 1'b0};
	assign m_w2 = {i_m_width, 1'b0};
	assign m_h2 = {i_m_height, 1'b0};

	scaler_pkg::mul_t y_thr [`SCALER_WEIGHT_STEPS];
	scaler_pkg::mul_t x_thr [`SCALER_WEIGHT_STEPS];

	// Thresholds at 1/8, 3/8, 5/8 and 7/8 of a source pitch
	always_ff @(posedge clk) begin
		if (int_reset) begin
			for (int i = 0; i < `SCALER_WEIGHT_STEPS; i++) begin
				y_thr[i] <= scaler_pkg::mul_t'((32'(i_m_height) * (2*i + 1))
					/ `SCALER_WEIGHT_STEPS);
				x_thr[i] <= scaler_pkg::mul_t'((32'(i_m_width) * (2*i + 1))
					/ `SCALER_WEIGHT_STEPS);
			end
		end
	end

	//////////////////////////////////////////////////
	// Input side

	logic s_next, s_last;
	logic [`SCALER_BUF_NUM-1:0] wr_act, buf_valid;
	logic wr_last;
	logic advance_read, iy_first;
	scaler_pkg::buf_sel_t rd_which, rd_which_pre;

	assign s_next = i_s_tvalid && o_s_tready;
	assign s_last = s_next && i_s_tlast;

	always_ff @(posedge clk) begin
		if (int_reset) begin
			o_s_tready <= 1'b0;
			wr_act <= `SCALER_BUF_NUM'(1);
		end else begin
			if (!o_s_tready && |(~buf_valid & wr_act))
				o_s_tready <= 1'b1;
			else if (s_last)
				o_s_tready <= 1'b0;
			if (s_last)
				wr_act <= {wr_act[`SCALER_BUF_NUM-2:0], wr_act[`SCALER_BUF_NUM-1]};
		end
	end

	always_ff @(posedge clk) begin
		if (int_reset) begin
			o_wr_en <= '0;
			o_wr_addr <= '0;
			wr_last <= 1'b0;
			buf_valid <= '0;
		end else begin
			o_wr_en <= wr_act & {`SCALER_BUF_NUM{s_next}};
			if (|o_wr_en)
				o_wr_addr <= wr_last ? '0 : o_wr_addr + 1'b1;
			if (s_next)
				wr_last <= i_s_tlast;
			for (int i = 0; i < `SCALER_BUF_NUM; i++) begin
				if (s_last && wr_act[i])
					buf_valid[i] <= 1'b1;
				else if (advance_read && rd_which_pre == scaler_pkg::buf_sel_t'(i)
						&& !iy_first)
					buf_valid[i] <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (s_next)
			o_wr_data <= i_s_tdata;
	end

	//////////////////////////////////////////////////
	// Vertical stepping

	scaler_pkg::mul_t iy_mul, oy_mul, ymul_diff;
	scaler_pkg::reso_t iy_line, oy_line;
	scaler_pkg::weight_t y_weight;
	logic iy_last, oy_last, oy_valid, oy_done, oy_posedge;
	logic advance_out, advance_out_d1;
	logic out_next, op_last_cur;

	always_ff @(posedge clk) begin
		if (int_reset) begin
			advance_out <= 1'b0;
			advance_out_d1 <= 1'b0;
			advance_read <= 1'b0;
			oy_done <= 1'b0;
			oy_posedge <= 1'b0;
		end else begin
			advance_out <= !advance_out && !oy_valid && !advance_out_d1 && !oy_last
				&& (mul_ge(iy_mul, oy_mul) || iy_last) && buf_valid[rd_which];
			advance_out_d1 <= advance_out;
			advance_read <= !advance_read && !oy_valid && buf_valid[rd_which]
				&& !mul_ge(iy_mul, oy_mul) && !iy_last;
			oy_done <= !oy_done && oy_valid && op_last_cur && out_next;
			oy_posedge <= advance_out_d1;
		end
	end

	always_ff @(posedge clk) begin
		if (mul_ge(iy_mul, oy_mul))
			ymul_diff <= iy_first ? '0 : iy_mul - oy_mul;
		else if (iy_last)
			ymul_diff <= '0;
	end

	always_ff @(posedge clk) begin
		if (int_reset) begin
			y_weight <= '0;
			oy_valid <= 1'b0;
			oy_last <= 1'b0;
			oy_line <= i_m_height;
			oy_mul <= scaler_pkg::mul_t'(i_s_height);
		end else begin
			if (advance_out_d1) begin
				y_weight <= quantize(ymul_diff, y_thr);
				oy_valid <= 1'b1;
				oy_last <= (oy_line == 1);
			end else if (oy_done) begin
				oy_valid <= 1'b0;
			end
			if (oy_done) begin
				oy_line <= oy_line - 1'b1;
				oy_mul <= oy_mul + s_h2;
			end
		end
	end

	// Top line is rd_which_pre, bottom line is rd_which
	always_ff @(posedge clk) begin
		if (int_reset) begin
			rd_which_pre <= '0;
			rd_which <= '0;
			iy_mul <= scaler_pkg::mul_t'(i_m_height);
			iy_line <= i_s_height;
			iy_last <= (i_s_height == 1);
			iy_first <= 1'b1;
		end else if (advance_read) begin
			rd_which_pre <= rd_which;
			if (!iy_last) begin
				rd_which <= rd_which + 1'b1;
				iy_mul <= iy_mul + m_h2;
				iy_line <= iy_line - 1'b1;
				iy_last <= (iy_line == 2);
				iy_first <= 1'b0;
			end
		end
	end

	//////////////////////////////////////////////////
	// Horizontal stepping

	logic line_reset, rd_en, ox_ready, ip_last, op_last, rd_line_done;
	scaler_pkg::mul_t ip_mul, ip_mul_cur, ip_mul_next, op_mul, op_mul_n, xmul_diff;
	scaler_pkg::reso_t ip_idx, op_idx;
	scaler_pkg::col_state_e col_state;
	scaler_pkg::pixel_t rd_data [`SCALER_BUF_NUM];
	scaler_pkg::pixel_t rd_top, rd_bot, left_top, left_bot;

	assign rd_data[0] = i_rd_data0;
	assign rd_data[1] = i_rd_data1;
	assign rd_data[2] = i_rd_data2;
	assign rd_data[3] = i_rd_data3;
	assign rd_top = rd_data[rd_which_pre];
	assign rd_bot = rd_data[rd_which];

	assign line_reset = int_reset || !oy_valid;
	assign ox_ready = !o_pair_valid || i_pair_ready;
	assign out_next = col_state[1] && ox_ready;
	assign rd_en = oy_valid && !rd_line_done
		&& (!col_state[1] || (col_state == scaler_pkg::COL_SINGLE && ox_ready));
	assign ip_mul = rd_en ? ip_mul_next : ip_mul_cur;
	assign o_rd_en = rd_en;

	always_ff @(posedge clk) begin
		if (line_reset) begin
			o_rd_addr <= '0;
			ip_mul_cur <= '0;
			ip_mul_next <= scaler_pkg::mul_t'(i_m_width);
			ip_idx <= i_s_width;
			ip_last <= (i_s_width == 1);
			rd_line_done <= 1'b0;
		end else if (rd_en) begin
			o_rd_addr <= o_rd_addr + 1'b1;
			ip_mul_cur <= ip_mul_next;
			ip_mul_next <= ip_mul_next + m_w2;
			if (!ip_last) begin
				ip_idx <= ip_idx - 1'b1;
				ip_last <= (ip_idx == 2);
			end
			if (ip_last || (mul_ge(ip_mul, op_mul) && op_last))
				rd_line_done <= 1'b1;
		end
	end

	// op_mul runs one output ahead of the pending one
	always_ff @(posedge clk) begin
		if (line_reset) begin
			op_mul <= scaler_pkg::mul_t'(i_s_width);
			op_mul_n <= (i_m_width == 1) ? scaler_pkg::mul_t'(i_s_width) : s_w2 + i_s_width;
			op_idx <= i_m_width;
			op_last <= (i_m_width == 1);
			op_last_cur <= (i_m_width == 1);
		end else begin
			if (!op_last && (rd_en ? (mul_ge(ip_mul, op_mul) || ip_last) : out_next)) begin
				op_mul <= op_mul_n;
				if (op_idx != 1) begin
					op_mul_n <= op_mul_n + s_w2;
					op_idx <= op_idx - 1'b1;
				end
				op_last <= (op_idx == 2);
			end
			if (out_next)
				op_last_cur <= op_last;
		end
	end

	always_ff @(posedge clk) begin
		if (line_reset) begin
			col_state <= scaler_pkg::COL_IDLE;
		end else if (out_next || rd_en) begin
			if (out_next && op_last_cur) begin
				col_state <= scaler_pkg::COL_IDLE;
			end else if (mul_ge(ip_mul, op_mul)) begin
				col_state <= mul_ge(ip_mul, op_mul_n) ? scaler_pkg::COL_MULTI
					: scaler_pkg::COL_SINGLE;
				xmul_diff <= oy_posedge ? '0 : ip_mul - op_mul;
			end else if (ip_last) begin
				col_state <= scaler_pkg::COL_SINGLE;
				xmul_diff <= '0;
			end else begin
				col_state <= scaler_pkg::COL_SKIP;
			end
		end
	end

	// Left column, zero at the start of a line
	always_ff @(posedge clk) begin
		if (rd_en) begin
			left_top <= oy_posedge ? '0 : rd_top;
			left_bot <= oy_posedge ? '0 : rd_bot;
		end
	end

	//////////////////////////////////////////////////
	// Pair to blend

	always_ff @(posedge clk) begin
		if (int_reset) begin
			o_pair_valid <= 1'b0;
			o_pair_last <= 1'b0;
		end else if (out_next) begin
			o_pair_valid <= 1'b1;
			o_pair_last <= op_last_cur;
		end else if (i_pair_ready) begin
			o_pair_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (out_next) begin
			o_tl <= left_top;
			o_bl <= left_bot;
			o_tr <= rd_top;
			o_br <= rd_bot;
			o_y_weight <= y_weight;
			o_x_weight <= quantize(xmul_diff, x_thr);
		end
	end

endmodule

`default_nettype wire

// ==== src/bilinear_blend.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "scaler_settings.svh"

module bilinear_blend (
	input  wire                      clk,
	input  wire                      int_reset,
	input  wire                      i_pair_valid,
	output logic                     o_pair_ready,
	input  wire scaler_pkg::pixel_t  i_tl,
	input  wire scaler_pkg::pixel_t  i_bl,
	input  wire scaler_pkg::pixel_t  i_tr,
	input  wire scaler_pkg::pixel_t  i_br,
	input  wire scaler_pkg::weight_t i_y_weight,
	input  wire scaler_pkg::weight_t i_x_weight,
	input  wire                      i_pair_last,
	output logic                     o_m_tvalid,
	output scaler_pkg::pixel_t       o_m_tdata,
	output logic                     o_m_tuser,
	output logic                     o_m_tlast,
	input  wire                      i_m_tready
);

	// a weighted by w, b by the complement, in quarters
	function automatic scaler_pkg::pixel_t mix(input scaler_pkg::pixel_t a,
			input scaler_pkg::pixel_t b, input scaler_pkg::weight_t w);
		logic [`SCALER_PIXEL_WIDTH+3:0] sum;
		scaler_pkg::weight_t wc;
		wc = scaler_pkg::weight_t'(`SCALER_WEIGHT_STEPS - w);
		sum = a * w + b * wc;
		return scaler_pkg::pixel_t'(sum / `SCALER_WEIGHT_STEPS);
	endfunction

	logic s1_valid, s1_last, s1_ready, s2_ready;
	scaler_pkg::pixel_t s1_left, s1_right;
	scaler_pkg::weight_t s1_x_weight;

	assign s2_ready = !o_m_tvalid || i_m_tready;
	assign s1_ready = !s1_valid || s2_ready;
	assign o_pair_ready = s1_ready;

	//////////////////////////////////////////////////
	// Stage one, vertical

	always_ff @(posedge clk) begin
		if (int_reset) begin
			s1_valid <= 1'b0;
			s1_last <= 1'b0;
		end else if (i_pair_valid && s1_ready) begin
			s1_valid <= 1'b1;
			s1_last <= i_pair_last;
		end else if (s2_ready) begin
			s1_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (i_pair_valid && s1_ready) begin
			s1_left <= mix(i_tl, i_bl, i_y_weight);
			s1_right <= mix(i_tr, i_br, i_y_weight);
			s1_x_weight <= i_x_weight;
		end
	end

	//////////////////////////////////////////////////
	// Stage two, horizontal and output

	always_ff @(posedge clk) begin
		if (int_reset) begin
			o_m_tvalid <= 1'b0;
			o_m_tlast <= 1'b0;
		end else if (s1_valid && s2_ready) begin
			o_m_tvalid <= 1'b1;
			o_m_tlast <= s1_last;
		end else if (i_m_tready) begin
			o_m_tvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (s1_valid && s2_ready)
			o_m_tdata <= mix(s1_left, s1_right, s1_x_weight);
	end

	// Start of frame rides on the first transfer only
	always_ff @(posedge clk) begin
		if (int_reset)
			o_m_tuser <= 1'b1;
		else if (o_m_tvalid && i_m_tready)
			o_m_tuser <= 1'b0;
	end

endmodule

`default_nettype wire

// ==== src/scaler_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "scaler_settings.svh"

module scaler_top (
	input  wire                     clk,
	input  wire                     int_reset,
	input  wire                     i_fsync,
	input  wire scaler_pkg::reso_t  i_s_width,
	input  wire scaler_pkg::reso_t  i_s_height,
	input  wire scaler_pkg::reso_t  i_m_width,
	input  wire scaler_pkg::reso_t  i_m_height,
	input  wire                     i_s_tvalid,
	input  wire scaler_pkg::pixel_t i_s_tdata,
	input  wire                     i_s_tuser,
	input  wire                     i_s_tlast,
	output wire                     o_s_tready,
	output wire                     o_m_tvalid,
	output wire scaler_pkg::pixel_t o_m_tdata,
	output wire                     o_m_tuser,
	output wire                     o_m_tlast,
	input  wire                     i_m_tready
);

	// Frame sync restarts everything below
	wire frame_reset;
	assign frame_reset = int_reset || i_fsync;

	wire [`SCALER_BUF_NUM-1:0] wr_en;
	scaler_pkg::reso_t wr_addr, rd_addr;
	scaler_pkg::pixel_t wr_data;
	scaler_pkg::pixel_t rd_data [`SCALER_BUF_NUM];
	wire rd_en;

	wire pair_valid, pair_ready, pair_last;
	scaler_pkg::pixel_t tl, bl, tr, br;
	scaler_pkg::weight_t y_weight, x_weight;

	scale_control u_control (
		.clk(clk),
		.int_reset(frame_reset),
		.i_s_width(i_s_width),
		.i_s_height(i_s_height),
		.i_m_width(i_m_width),
		.i_m_height(i_m_height),
		.i_s_tvalid(i_s_tvalid),
		.i_s_tdata(i_s_tdata),
		.i_s_tlast(i_s_tlast),
		.o_s_tready(o_s_tready),
		.o_wr_en(wr_en),
		.o_wr_addr(wr_addr),
		.o_wr_data(wr_data),
		.o_rd_en(rd_en),
		.o_rd_addr(rd_addr),
		.i_rd_data0(rd_data[0]),
		.i_rd_data1(rd_data[1]),
		.i_rd_data2(rd_data[2]),
		.i_rd_data3(rd_data[3]),
		.o_pair_valid(pair_valid),
		.i_pair_ready(pair_ready),
		.o_tl(tl),
		.o_bl(bl),
		.o_tr(tr),
		.o_br(br),
		.o_y_weight(y_weight),
		.o_x_weight(x_weight),
		.o_pair_last(pair_last)
	);

	for (genvar i = 0; i < `SCALER_BUF_NUM; i++) begin : g_line
		line_buffer u_line (
			.clk(clk),
			.i_wr_en(wr_en[i]),
			.i_wr_addr(wr_addr),
			.i_wr_data(wr_data),
			.i_rd_en(rd_en),
			.i_rd_addr(rd_addr),
			.o_rd_data(rd_data[i])
		);
	end

	bilinear_blend u_blend (
		.clk(clk),
		.int_reset(frame_reset),
		.i_pair_valid(pair_valid),
		.o_pair_ready(pair_ready),
		.i_tl(tl),
		.i_bl(bl),
		.i_tr(tr),
		.i_br(br),
		.i_y_weight(y_weight),
		.i_x_weight(x_weight),
		.i_pair_last(pair_last),
		.o_m_tvalid(o_m_tvalid),
		.o_m_tdata(o_m_tdata),
		.o_m_tuser(o_m_tuser),
		.o_m_tlast(o_m_tlast),
		.i_m_tready(i_m_tready)
	);

endmodule

`default_nettype wire

// ==== bench/scaler_top_properties.sv ====
`timescale 1ns/1ns
`default_nettype none

module scaler_top_properties (
	input wire                     clk,
	input wire                     int_reset,
	input wire                     i_fsync,
	input wire                     i_out_valid,
	input wire scaler_pkg::pixel_t i_out_data,
	input wire                     i_out_ready,
	input wire                     i_in_valid,
	input wire                     i_in_ready,
	input wire                     i_in_last
);

	int unsigned failures = 0;

	wire frame_reset;
	assign frame_reset = int_reset || i_fsync;

	// Output stream idle right after any reset
	a_valid_after_reset: assert property (@(posedge clk) frame_reset |=> !i_out_valid)
	else begin
		failures++;
		$error("output valid high in the cycle after reset");
	end

	a_data_held: assert property (@(posedge clk) disable iff (frame_reset)
		i_out_valid && !i_out_ready |=> $stable(i_out_data))
	else begin
		failures++;
		$error("output data changed while stalled");
	end

	// Input pauses after each accepted line end
	a_ready_after_last: assert property (@(posedge clk) disable iff (frame_reset)
		i_in_valid && i_in_ready && i_in_last |=> !i_in_ready)
	else begin
		failures++;
		$error("input ready still high after an accepted last");
	end

endmodule

`default_nettype wire

// ==== bench/scaler_top_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module scaler_top_tb;

	localparam int NUM_ROWS = 10;
	localparam int MAX_OUT = 128;
	localparam int PAT_CONST = 0;
	localparam int PAT_IDENT = 1;
	localparam int PAT_HRAMP = 2;

	logic clk = 1'b0;
	logic int_reset, i_fsync;
	scaler_pkg::reso_t i_s_width, i_s_height, i_m_width, i_m_height;
	logic i_s_tvalid, i_s_tuser, i_s_tlast;
	scaler_pkg::pixel_t i_s_tdata;
	logic o_s_tready, o_m_tvalid, o_m_tuser, o_m_tlast;
	scaler_pkg::pixel_t o_m_tdata;
	logic i_m_tready = 1'b1;

	scaler_top i_dut (.*);

	bind scaler_top scaler_top_properties u_props (
		.clk(clk),
		.int_reset(int_reset),
		.i_fsync(i_fsync),
		.i_out_valid(o_m_tvalid),
		.i_out_data(o_m_tdata),
		.i_out_ready(i_m_tready),
		.i_in_valid(i_s_tvalid),
		.i_in_ready(o_s_tready),
		.i_in_last(i_s_tlast)
	);

	always #2 clk = ~clk;

	// Test table
	string row_name [NUM_ROWS];
	int row_sw [NUM_ROWS], row_sh [NUM_ROWS], row_mw [NUM_ROWS], row_mh [NUM_ROWS];
	int row_pattern [NUM_ROWS], row_value [NUM_ROWS], row_ref [NUM_ROWS];
	bit row_random [NUM_ROWS], row_restart [NUM_ROWS];
	int rows_added = 0;

	int saved [NUM_ROWS][MAX_OUT];
	int got [MAX_OUT];
	int row, out_count, exp_count;
	int cycles = 0;
	int cycle_limit;
	bit collect = 1'b0;
	bit rand_ready = 1'b0;
	integer seed = 58600;
	logic [31:0] rnd_word;

	task automatic stop_with(string msg);
		$display("%s", msg);
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	task automatic check_value(string what, int expected, int actual);
		assert (expected == actual)
		else stop_with($sformatf("mismatch in %s, %s: expected %0d, actual %0d",
			row_name[row], what, expected, actual));
	endtask

	task automatic add_row(string name, int sw, int sh, int mw, int mh, int pattern,
			int value, bit rnd, int ref_row, bit restart);
		row_name[rows_added] = name;
		row_sw[rows_added] = sw;
		row_sh[rows_added] = sh;
		row_mw[rows_added] = mw;
		row_mh[rows_added] = mh;
		row_pattern[rows_added] = pattern;
		row_value[rows_added] = value;
		row_random[rows_added] = rnd;
		row_ref[rows_added] = ref_row;
		row_restart[rows_added] = restart;
		rows_added++;
	endtask

	function automatic int pixel_value(int r, int x, int y);
		case (row_pattern[r])
			PAT_IDENT: return ((y * row_sw[r] + x) * row_value[r] + 1) % 256;
			PAT_HRAMP: return x * row_value[r] + 10;
			default:   return row_value[r];
		endcase
	endfunction

	//////////////////////////////////////////////////
	// Output monitor, also drives ready

	always @(negedge clk) begin
		assert (i_dut.u_props.failures == 0)
		else stop_with("a stream protocol assertion fired at the DUT ports");
		if (rand_ready) begin
			rnd_word = $random(seed);
			i_m_tready = rnd_word[0];
		end else begin
			i_m_tready = 1'b1;
		end
		if (collect && o_m_tvalid && i_m_tready) begin
			assert (out_count < exp_count)
			else stop_with($sformatf("%s: output beyond the end of the frame", row_name[row]));
			check_value("tuser", out_count == 0, o_m_tuser);
			check_value("tlast", ((out_count + 1) % row_mw[row]) == 0, o_m_tlast);
			got[out_count] = o_m_tdata;
			out_count++;
		end
	end

	always @(posedge clk) begin
		cycles++;
		assert (cycles < cycle_limit)
		else stop_with("timeout: frames did not complete within the cycle limit");
	end

	//////////////////////////////////////////////////
	// Frame tasks

	task automatic start_frame(int r, bit collect_en);
		collect <= 1'b0;
		i_s_width = scaler_pkg::reso_t'(row_sw[r]);
		i_s_height = scaler_pkg::reso_t'(row_sh[r]);
		i_m_width = scaler_pkg::reso_t'(row_mw[r]);
		i_m_height = scaler_pkg::reso_t'(row_mh[r]);
		i_fsync = 1'b1;
		@(negedge clk);
		i_fsync = 1'b0;
		@(negedge clk);
		out_count = 0;
		exp_count = row_mw[r] * row_mh[r];
		rand_ready <= row_random[r];
		collect <= collect_en;
	endtask

	// Stops early once the whole output frame is seen
	task automatic send_frame(int r, int lines, bit junk);
		for (int y = 0; y < lines; y++) begin
			for (int x = 0; x < row_sw[r]; x++) begin
				i_s_tvalid = 1'b1;
				i_s_tdata = junk ? 8'hee : scaler_pkg::pixel_t'(pixel_value(r, x, y));
				i_s_tuser = (x == 0 && y == 0);
				i_s_tlast = (x == row_sw[r] - 1);
				while (!o_s_tready && out_count < exp_count)
					@(negedge clk);
				@(negedge clk);
			end
		end
		i_s_tvalid = 1'b0;
		i_s_tuser = 1'b0;
		i_s_tlast = 1'b0;
	endtask

	task automatic wait_frame();
		while (out_count < exp_count)
			@(negedge clk);
		// Drain window to catch extra outputs
		repeat (20) @(negedge clk);
	endtask

	task automatic check_content(int r);
		int lo, hi, mw;
		lo = pixel_value(r, 0, 0);
		hi = pixel_value(r, row_sw[r] - 1, 0);
		mw = row_mw[r];
		for (int i = 0; i < exp_count; i++) begin
			if (row_pattern[r] == PAT_IDENT)
				check_value("pixel", pixel_value(r, i % row_sw[r], i / row_sw[r]), got[i]);
			else if (row_pattern[r] == PAT_CONST)
				check_value("pixel", row_value[r], got[i]);
			else begin
				assert (got[i] >= lo && got[i] <= hi)
				else stop_with($sformatf(
					"mismatch in %s, pixel %0d: expected %0d to %0d, actual %0d",
					row_name[r], i, lo, hi, got[i]));
				if (i % mw != 0)
					assert (got[i] >= got[i-1])
					else stop_with($sformatf(
						"mismatch in %s, pixel %0d: expected at least %0d, actual %0d",
						row_name[r], i, got[i-1], got[i]));
			end
			if (row_ref[r] >= 0)
				check_value("stalled pixel", saved[row_ref[r]][i], got[i]);
			saved[r][i] = got[i];
		end
	endtask

	task automatic run_row(int r);
		row = r;
		// Part of a junk frame, then a sync pulse in its middle
		if (row_restart[r]) begin
			start_frame(r, 1'b0);
			send_frame(r, 3, 1'b1);
			repeat (10) @(negedge clk);
		end
		start_frame(r, 1'b1);
		fork
			send_frame(r, row_sh[r], 1'b0);
			wait_frame();
		join
		check_content(r);
	endtask

	//////////////////////////////////////////////////
	// Main sequence

	initial begin
		add_row("identity_8x6", 8, 6, 8, 6, PAT_IDENT, 3, 1'b0, -1, 1'b0);
		add_row("const_up", 6, 4, 11, 7, PAT_CONST, 173, 1'b0, -1, 1'b0);
		add_row("const_down", 12, 9, 7, 5, PAT_CONST, 58, 1'b0, -1, 1'b0);
		add_row("hramp_up", 6, 4, 13, 6, PAT_HRAMP, 40, 1'b0, -1, 1'b0);
		add_row("hramp_down", 16, 6, 9, 4, PAT_HRAMP, 15, 1'b0, -1, 1'b0);
		add_row("const_up_stall", 6, 4, 11, 7, PAT_CONST, 173, 1'b1, 1, 1'b0);
		add_row("const_down_stall", 12, 9, 7, 5, PAT_CONST, 58, 1'b1, 2, 1'b0);
		add_row("hramp_up_stall", 6, 4, 13, 6, PAT_HRAMP, 40, 1'b1, 3, 1'b0);
		add_row("hramp_down_stall", 16, 6, 9, 4, PAT_HRAMP, 15, 1'b1, 4, 1'b0);
		add_row("restart_8x6", 8, 6, 8, 6, PAT_IDENT, 5, 1'b0, -1, 1'b1);

		cycle_limit = 0;
		for (int r = 0; r < NUM_ROWS; r++)
			cycle_limit += 20 * ((row_sw[r] * row_sh[r] > row_mw[r] * row_mh[r])
				? row_sw[r] * row_sh[r] : row_mw[r] * row_mh[r]);

		int_reset = 1'b1;
		i_fsync = 1'b0;
		i_s_width = '0;
		i_s_height = '0;
		i_m_width = '0;
		i_m_height = '0;
		i_s_tvalid = 1'b0;
		i_s_tdata = '0;
		i_s_tuser = 1'b0;
		i_s_tlast = 1'b0;
		repeat (4) @(negedge clk);
		int_reset = 1'b0;

		for (int r = 0; r < NUM_ROWS; r++)
			run_row(r);

		if (i_dut.u_props.failures == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== scaler_top.f ====
+incdir+src
src/scaler_pkg.sv
src/line_buffer.sv
src/scale_control.sv
src/bilinear_blend.sv
src/scaler_top.sv
bench/scaler_top_properties.sv
bench/scaler_top_tb.sv

// ==== Makefile ====
TOP := scaler_top_tb

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "ALL CHECKS PASSED"

obj_dir/V$(TOP): scaler_top.f src/*.sv src/*.svh bench/*.sv
	verilator --binary --timing --assert -Wno-fatal -f scaler_top.f \
		--top-module $(TOP) --Mdir obj_dir

lint:
	verilator --lint-only --timing --assert -Wall -f scaler_top.f \
		--top-module $(TOP)

clean:
	rm -rf obj_dir
